//--- Makefile
VERILATOR ?= verilator
TOP       ?= sdram_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation completed successfully
SOURCES   := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/sdram_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_checker (
    input  logic                CLK,
    input  logic                rst,
    input  sdram_pkg::rd_rsp_t  rsp,
    input  logic                rsp_valid,
    input  logic                init_done,
    input  logic [15:0]         ref_count,
    input  logic                cs_n,
    input  logic                ras_n,
    input  logic                cas_n,
    input  logic                we_n,
    input  logic [1:0]          dqm,
    input  logic                exp_push,
    input  sdram_pkg::tag_t     exp_tag,
    input  sdram_pkg::data_t    exp_data,
    input  logic [15:0]         ref_limit,
    input  logic [15:0]         ref_base,
    input  int                  credits,
    input  logic                end_check,
    output int                  pend_cnt,
    output int                  pass_cnt,
    output int                  fail_cnt
);
    import sdram_pkg::*;

    localparam logic [2:0] PIN_NOP = 3'b111;
    localparam logic [2:0] PIN_REF = 3'b001;
    localparam logic [2:0] PIN_PRE = 3'b010;
    localparam logic [2:0] PIN_ACT = 3'b011;
    localparam logic [2:0] PIN_MRS = 3'b000;

    rd_rsp_t     exp_q [$];
    logic [2:0]  pin_op;
    logic [2:0]  first_op;
    logic        first_seen;
    logic        init_seen;
    int          n_pre;
    int          n_ref;
    int          n_mrs;
    int          n_act;
    int          n_run_ref;  // REF commands at the pins after init
    int          gap;        // Cycles since the last REF at the pins
    logic [15:0] cur_limit;
    logic        late;
    logic        spacing_bad;
    logic        credit_bad;
    logic        dqm_bad;

    assign pin_op = cs_n ? PIN_NOP : {ras_n, cas_n, we_n};

    task automatic report(input string name, input logic ok);
        if (ok) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s", name);
        end
    endtask

    function automatic logic count_ok(input string name, input int exp, input int act);
        if (exp == act) return 1'b1;
        $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        return 1'b0;
    endfunction

    always @(posedge CLK) begin : watch
        rd_rsp_t exp;
        logic    ok;
        if (rst) begin
            exp_q.delete();
            {first_seen, init_seen, late, spacing_bad, credit_bad, dqm_bad} = '0;
            first_op  = PIN_NOP;
            n_pre     = 0;
            n_ref     = 0;
            n_mrs     = 0;
            n_act     = 0;
            n_run_ref = 0;
            gap       = 0;
            cur_limit = ref_limit;
            pend_cnt  = 0;
            pass_cnt  = 0;
            fail_cnt  = 0;
        end else begin
            if (exp_push) exp_q.push_back(rd_rsp_t'{data: exp_data, tag: exp_tag});

            if (!init_done) begin
                if (pin_op != PIN_NOP && !first_seen) begin
                    first_seen = 1'b1;
                    first_op   = pin_op;
                end
                if (pin_op == PIN_PRE) n_pre++;
                if (pin_op == PIN_REF) n_ref++;
                if (pin_op == PIN_MRS) n_mrs++;
                if (pin_op == PIN_ACT) n_act++;
            end else if (!init_seen) begin
                init_seen = 1'b1;
                ok = (first_op == PIN_PRE);
                if (!ok) $display("First command after reset was not a PRE");
                ok = count_ok("PRE count", 1, n_pre) && ok;
                ok = count_ok("REF count", 2, n_ref) && ok;
                ok = count_ok("MRS count", 1, n_mrs) && ok;
                ok = count_ok("ACT count", 0, n_act) && ok;
                report("init sequence", ok);
            end

            if (init_done && pin_op == PIN_REF) n_run_ref++;

            if (init_done && !late && gap > cur_limit) begin
                $display("No REF for %0d cycles at %0t, limit is %0d", gap, $time, cur_limit);
                late        = 1'b1;
                spacing_bad = 1'b1;
            end
            if (pin_op == PIN_REF) begin
                gap       = 1;
                cur_limit = ref_limit; // A new interval applies from this REF on
                late      = 1'b0;
            end else begin
                gap++;
            end

            if ((credits < 0 || credits > `SDRAM_REQ_DEPTH) && !credit_bad) begin
                $display("Host credit count left its range at %0t: %0d", $time, credits);
                credit_bad = 1'b1;
            end

            if (dqm !== 2'b00 && !dqm_bad) begin
                $display("Mismatch at %0t: dram_dqm expected %b actual %b",
                         $time, 2'b00, dqm);
                dqm_bad = 1'b1;
            end

            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Read response with tag %0d came with no read outstanding", rsp.tag);
                    report("unexpected response", 1'b0);
                end else begin
                    exp = exp_q.pop_front();
                    ok  = 1'b1;
                    if (rsp.tag !== exp.tag) begin
                        $display("Mismatch at %0t: rsp.tag expected %0d actual %0d",
                                 $time, exp.tag, rsp.tag);
                        ok = 1'b0;
                    end
                    if (rsp.data !== exp.data) begin
                        $display("Mismatch at %0t: rsp.data expected %h actual %h",
                                 $time, exp.data, rsp.data);
                        ok = 1'b0;
                    end
                    report($sformatf("read tag %0d", exp.tag), ok);
                end
            end
            pend_cnt = exp_q.size();

            if (end_check) begin
                report("refresh spacing", !spacing_bad);
                ok = count_ok("credits", `SDRAM_REQ_DEPTH, credits) && !credit_bad;
                report("credit return", ok);
                ok = count_ok("ref_count", n_run_ref, int'(ref_count));
                if (ref_count <= ref_base) begin
                    $display("Mismatch at %0t: ref_count expected above %0d actual %0d",
                             $time, ref_base, ref_count);
                    ok = 1'b0;
                end
                report("refresh count", ok);
                report("byte masks", !dqm_bad);
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/sdram_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_model #(
    parameter int CAS = `SDRAM_CAS
) (
    input  wire        CLK,
    inout  wire [15:0] dq,
    input  wire [12:0] addr,
    input  wire [1:0]  ba,
    input  wire        cke,
    input  wire        cs_n,
    input  wire        ras_n,
    input  wire        cas_n,
    input  wire        we_n
);
    logic [15:0]          mem [logic [23:0]]; // Keyed by bank, row and column
    logic [12:0]          open_row [4];
    logic [CAS-1:0]       rd_sr = '0;
    logic [CAS-1:0][15:0] rd_pipe;
    logic [2:0]           op;
    logic [23:0]          key;

    // Never-written words read back as a pattern of their whole address
    function automatic logic [15:0] fill_word(input logic [23:0] a);
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'hc3a5;
    endfunction

    initial begin
        for (int i = 0; i < 4; i++) begin
            open_row[i] = '0;
        end
    end

    assign op  = (cke && !cs_n) ? {ras_n, cas_n, we_n} : 3'b111;
    assign key = {ba, open_row[ba], addr[8:0]};

    always @(posedge CLK) begin
        rd_sr   <= {rd_sr[CAS-2:0], op == 3'b101};
        rd_pipe <= {rd_pipe[CAS-2:0], mem.exists(key) ? mem[key] : fill_word(key)};
        if (op == 3'b011) open_row[ba] <= addr; // ACT
        if (op == 3'b100) begin
            mem[key] = dq; // WRITE data arrives with the command
        end
    end

    // Read word sits on DQ during the cycle before the CAS edge
    assign dq = rd_sr[CAS-1] ? rd_pipe[CAS-1] : 'z;

endmodule

`default_nettype wire

//--- bench/sdram_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_tb;
    import sdram_pkg::*;

    localparam int          NUM_TESTS  = 19;
    localparam int          DEPTH      = `SDRAM_REQ_DEPTH;
    localparam int          MAX_CYCLES = `SDRAM_T_INIT + 40 * NUM_TESTS + 500;
    localparam logic [15:0] NEW_IVL    = 16'd60;
    localparam logic [15:0] SLACK      = 16'(`SDRAM_T_RCD + `SDRAM_T_RC);

    typedef struct packed {
        logic [2:0] wait_refs; // Refreshes to see before this entry goes out
        host_req_t  req;
        data_t      exp;
    } entry_t;

    logic        CLK;
    logic        rst;
    host_req_t   req;
    logic        req_valid;
    logic        credit_ret;
    rd_rsp_t     rsp;
    logic        rsp_valid;
    logic        cfg_wr;
    logic [15:0] cfg_wdata;
    logic [15:0] ref_count;
    logic        init_done;
    wire  [15:0] dram_dq;
    logic [12:0] dram_addr;
    logic [1:0]  dram_ba;
    logic [1:0]  dram_dqm;
    logic        dram_clk;
    logic        dram_cke;
    logic        dram_cs_n;
    logic        dram_ras_n;
    logic        dram_cas_n;
    logic        dram_we_n;

    logic        exp_push;
    tag_t        exp_tag;
    data_t       exp_data;
    logic [15:0] ref_limit;
    logic [15:0] ref_base;
    logic        end_check;
    int          pend_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          sent_cnt = 0;
    int          ret_cnt  = 0;
    int          credits;
    int          cycles   = 0;
    entry_t      tests [NUM_TESTS];
    data_t       wd [8];

    sdram_ctrl_top dut_i (
        .CLK        (CLK),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .credit_ret (credit_ret),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .cfg_wr     (cfg_wr),
        .cfg_wdata  (cfg_wdata),
        .ref_count  (ref_count),
        .init_done  (init_done),
        .dram_dq    (dram_dq),
        .dram_addr  (dram_addr),
        .dram_ba    (dram_ba),
        .dram_dqm   (dram_dqm),
        .dram_clk   (dram_clk),
        .dram_cke   (dram_cke),
        .dram_cs_n  (dram_cs_n),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n)
    );

    sdram_model model_i (
        .CLK   (dram_clk),
        .dq    (dram_dq),
        .addr  (dram_addr),
        .ba    (dram_ba),
        .cke   (dram_cke),
        .cs_n  (dram_cs_n),
        .ras_n (dram_ras_n),
        .cas_n (dram_cas_n),
        .we_n  (dram_we_n)
    );

    sdram_checker chk_i (
        .CLK       (CLK),
        .rst       (rst),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .init_done (init_done),
        .ref_count (ref_count),
        .cs_n      (dram_cs_n),
        .ras_n     (dram_ras_n),
        .cas_n     (dram_cas_n),
        .we_n      (dram_we_n),
        .dqm       (dram_dqm),
        .exp_push  (exp_push),
        .exp_tag   (exp_tag),
        .exp_data  (exp_data),
        .ref_limit (ref_limit),
        .ref_base  (ref_base),
        .credits   (credits),
        .end_check (end_check),
        .pend_cnt  (pend_cnt),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    always #5 CLK = ~CLK;

    // A returned credit counts from the edge after the pulse
    always @(posedge CLK) begin
        if (credit_ret) ret_cnt <= ret_cnt + 1;
    end
    assign credits = DEPTH + ret_cnt - sent_cnt;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic entry_t make_entry(input logic w, input logic [1:0] b,
                                          input logic [12:0] r, input logic [8:0] c,
                                          input data_t d, input int tag, input int refs);
        entry_t e;
        e.wait_refs = 3'(refs);
        e.req       = '{write: w, bank: b, row: r, col: c, data: w ? d : '0, tag: 8'(tag)};
        e.exp       = d;
        return e;
    endfunction

    task automatic send_entry(input entry_t e);
        while (credits <= 0) @(negedge CLK);
        req       = e.req;
        req_valid = 1'b1;
        sent_cnt++;
        exp_push  = !e.req.write; // Only reads come back
        exp_tag   = e.req.tag;
        exp_data  = e.exp;
        @(negedge CLK);
        req_valid = 1'b0;
        exp_push  = 1'b0;
    endtask

    task automatic wait_refreshes(input int n);
        int base;
        while (credits != DEPTH) @(negedge CLK); // Earlier writes reach the DRAM first
        base = ref_count;
        while (int'(ref_count) < base + n) @(negedge CLK);
    endtask

    initial begin
        CLK       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        cfg_wr    = 1'b0;
        cfg_wdata = '0;
        exp_push  = 1'b0;
        exp_tag   = '0;
        exp_data  = '0;
        ref_limit = 16'(`SDRAM_REF_DEFAULT) + SLACK;
        ref_base  = '0;
        end_check = 1'b0;
        void'($urandom(32'h6225));
        for (int i = 0; i < 8; i++) begin
            wd[i] = 16'($urandom);
        end

        tests[0]  = make_entry(1'b1, 2'd0, 13'd5,    9'd3,   wd[0], 0,  0);
        tests[1]  = make_entry(1'b0, 2'd0, 13'd5,    9'd3,   wd[0], 1,  0);
        tests[2]  = make_entry(1'b1, 2'd1, 13'd100,  9'd10,  wd[1], 2,  0);
        tests[3]  = make_entry(1'b1, 2'd2, 13'd7,    9'd511, wd[2], 3,  0);
        tests[4]  = make_entry(1'b1, 2'd3, 13'd8191, 9'd0,   wd[3], 4,  0);
        tests[5]  = make_entry(1'b0, 2'd3, 13'd8191, 9'd0,   wd[3], 5,  0);
        tests[6]  = make_entry(1'b0, 2'd1, 13'd100,  9'd10,  wd[1], 6,  0);
        tests[7]  = make_entry(1'b0, 2'd2, 13'd7,    9'd511, wd[2], 7,  0);
        tests[8]  = make_entry(1'b1, 2'd0, 13'd20,   9'd1,   wd[4], 8,  0);
        tests[9]  = make_entry(1'b1, 2'd1, 13'd21,   9'd2,   wd[5], 9,  0);
        tests[10] = make_entry(1'b1, 2'd2, 13'd22,   9'd3,   wd[6], 10, 0);
        tests[11] = make_entry(1'b0, 2'd0, 13'd20,   9'd1,   wd[4], 11, 0);
        tests[12] = make_entry(1'b0, 2'd1, 13'd21,   9'd2,   wd[5], 12, 0);
        tests[13] = make_entry(1'b0, 2'd2, 13'd22,   9'd3,   wd[6], 13, 0);
        tests[14] = make_entry(1'b0, 2'd0, 13'd5,    9'd3,   wd[0], 14, 0);
        tests[15] = make_entry(1'b1, 2'd3, 13'd30,   9'd4,   wd[7], 15, 0);
        tests[16] = make_entry(1'b0, 2'd3, 13'd30,   9'd4,   wd[7], 16, 4);
        tests[17] = make_entry(1'b0, 2'd1, 13'd100,  9'd10,  wd[1], 17, 0);
        tests[18] = make_entry(1'b0, 2'd0, 13'd20,   9'd1,   wd[4], 18, 0);

        repeat (8) @(negedge CLK);
        rst = 1'b0;
        while (!init_done) @(negedge CLK);

        cfg_wr    = 1'b1;
        cfg_wdata = NEW_IVL;
        ref_limit = NEW_IVL + SLACK;
        ref_base  = ref_count;
        @(negedge CLK);
        cfg_wr = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tests[i].wait_refs != 0) wait_refreshes(int'(tests[i].wait_refs));
            send_entry(tests[i]);
        end
        while (pend_cnt != 0) @(negedge CLK); // Last read answered, queue drained

        end_check = 1'b1;
        @(negedge CLK);
        end_check = 1'b0;
        @(negedge CLK);

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/sdram_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_cfg_regs (
    input  logic        CLK,
    input  logic        rst,
    input  logic        cfg_wr,
    input  logic [15:0] cfg_wdata,
    input  logic        init_done_in,
    input  logic        ref_pulse,
    output logic [15:0] ref_interval,
    output logic [15:0] ref_count
);

    // Sequencer compares against this every cycle
    always_ff @(posedge CLK) begin
        if (rst) begin
            ref_interval <= 16'(`SDRAM_REF_DEFAULT);
        end else if (cfg_wr) begin
            ref_interval <= cfg_wdata;
        end
    end

    // Init-sequence refreshes are not counted
    always_ff @(posedge CLK) begin
        if (rst) begin
            ref_count <= '0;
        end else if (init_done_in && ref_pulse) begin
            ref_count <= ref_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_cmd_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_cmd_seq (
    input  logic                 CLK,
    input  logic                 rst,
    input  sdram_pkg::host_req_t req,
    input  logic                 req_valid,
    output logic                 credit_ret,
    input  logic [15:0]          ref_interval,
    output logic                 init_done,
    output logic                 ref_pulse,
    output sdram_pkg::cmd_t      cmd
);
    import sdram_pkg::*;

    localparam int PTR_W = $clog2(`SDRAM_REQ_DEPTH);

    localparam logic [15:0] T_INIT_W = 16'(`SDRAM_T_INIT - 1);
    localparam logic [15:0] T_RP_W   = 16'(`SDRAM_T_RP - 1);
    localparam logic [15:0] T_RFC_W  = 16'(`SDRAM_T_RFC - 1);
    localparam logic [15:0] T_MRD_W  = 16'(`SDRAM_T_MRD - 1);
    localparam logic [15:0] T_RCD_W  = 16'(`SDRAM_T_RCD - 1);
    localparam logic [15:0] T_RC_W   = 16'(`SDRAM_T_RC - 1);

    // Burst length 1, sequential, CAS latency in A6..A4
    localparam data_t MODE_WORD = {9'd0, 3'(`SDRAM_CAS), 4'b0000};
    localparam cmd_t  NOP_CMD   = '{op: OP_NOP, bank: '0, addr: '0, data: '0};

    host_req_t        q_mem [`SDRAM_REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   q_cnt;
    host_req_t        head;
    logic             pop;

    seq_state_t  state;
    logic [15:0] wait_cnt;
    logic [15:0] ref_cnt;    // Cycles since the last REF decision
    logic        ref_due;
    logic        ref_second;

    assign head    = q_mem[rd_ptr];
    assign pop     = (state == S_ACTIVATE) && (wait_cnt == '0);
    assign ref_due = ref_cnt >= ref_interval;

    // Credits guarantee a free slot on every push
    always_ff @(posedge CLK) begin
        if (req_valid) begin
            q_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (req_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            q_cnt      <= q_cnt + (PTR_W+1)'(req_valid) - (PTR_W+1)'(pop);
            credit_ret <= pop;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= S_INIT_WAIT;
            wait_cnt   <= T_INIT_W;
            ref_cnt    <= '0;
            ref_second <= 1'b0;
            init_done  <= 1'b0;
            ref_pulse  <= 1'b0;
            cmd        <= NOP_CMD;
        end else begin
            cmd       <= NOP_CMD;
            ref_pulse <= 1'b0;
            if (ref_cnt != '1) ref_cnt <= ref_cnt + 1'b1; // Saturates
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                case (state)
                    S_INIT_WAIT: begin
                        cmd.op       <= OP_PRE;
                        cmd.addr[10] <= 1'b1; // All banks
                        wait_cnt     <= T_RP_W;
                        state        <= S_PRECHARGE;
                    end
                    S_PRECHARGE: begin
                        cmd.op     <= OP_REF;
                        wait_cnt   <= T_RFC_W;
                        ref_cnt    <= 16'd1;
                        ref_pulse  <= 1'b1;
                        ref_second <= 1'b1;
                        state      <= S_REFRESH;
                    end
                    S_REFRESH: begin
                        if (ref_second) begin
                            cmd.op     <= OP_REF;
                            wait_cnt   <= T_RFC_W;
                            ref_cnt    <= 16'd1;
                            ref_pulse  <= 1'b1;
                            ref_second <= 1'b0;
                        end else begin
                            cmd.op   <= OP_MRS;
                            cmd.data <= MODE_WORD;
                            wait_cnt <= T_MRD_W;
                            state    <= S_MODE_SET;
                        end
                    end
                    S_MODE_SET: begin
                        init_done <= 1'b1;
                        state     <= S_IDLE;
                    end
                    S_IDLE: begin
                        if (ref_due) begin
                            cmd.op    <= OP_REF;
                            wait_cnt  <= T_RFC_W;
                            ref_cnt   <= 16'd1;
                            ref_pulse <= 1'b1;
                            state     <= S_RECOVER;
                        end else if (q_cnt != '0) begin
                            cmd.op   <= OP_ACT;
                            cmd.bank <= head.bank;
                            cmd.addr <= head.row;
                            wait_cnt <= T_RCD_W;
                            state    <= S_ACTIVATE;
                        end
                    end
                    S_ACTIVATE: begin
                        cmd.op   <= head.write ? OP_WRITE : OP_READ;
                        cmd.bank <= head.bank;
                        cmd.addr <= {3'b001, 1'b0, head.col}; // A10 auto-precharge
                        cmd.data <= head.write ? head.data : data_t'(head.tag);
                        wait_cnt <= T_RC_W;
                        state    <= S_ACCESS;
                    end
                    default: begin
                        state <= S_IDLE; // Access or refresh recovery done
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_consts.svh
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// DRAM timing in CLK cycles
`define SDRAM_T_RCD       3
`define SDRAM_T_RC        9
`define SDRAM_T_RP        3
`define SDRAM_T_MRD       2
`define SDRAM_T_RFC       9
`define SDRAM_T_INIT      200 // Short power-up wait for simulation

`define SDRAM_CAS         3   // 2 or 3

`define SDRAM_REQ_DEPTH   4   // Also the host's starting credit count
`define SDRAM_REF_DEFAULT 150

// Field widths
`define SDRAM_DATA_W      16
`define SDRAM_TAG_W       8
`define SDRAM_BANK_W      2
`define SDRAM_ROW_W       13
`define SDRAM_COL_W       9

`endif

//--- source/sdram_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_ctrl_top (
    input  logic                 CLK,
    input  logic                 rst,
    input  sdram_pkg::host_req_t req,
    input  logic                 req_valid,
    output logic                 credit_ret,
    output sdram_pkg::rd_rsp_t   rsp,
    output logic                 rsp_valid,
    input  logic                 cfg_wr,
    input  logic [15:0]          cfg_wdata,
    output logic [15:0]          ref_count,
    output logic                 init_done,
    inout  wire  [15:0]          dram_dq,
    output logic [12:0]          dram_addr,
    output logic [1:0]           dram_ba,
    output logic [1:0]           dram_dqm,
    output logic                 dram_clk,
    output logic                 dram_cke,
    output logic                 dram_cs_n,
    output logic                 dram_ras_n,
    output logic                 dram_cas_n,
    output logic                 dram_we_n
);
    import sdram_pkg::*;

    cmd_t        cmd;
    logic [15:0] ref_interval;
    logic        ref_pulse;

    sdram_cfg_regs cfg_i (
        .CLK          (CLK),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_wdata    (cfg_wdata),
        .init_done_in (init_done),
        .ref_pulse    (ref_pulse),
        .ref_interval (ref_interval),
        .ref_count    (ref_count)
    );

    sdram_cmd_seq seq_i (
        .CLK          (CLK),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .credit_ret   (credit_ret),
        .ref_interval (ref_interval),
        .init_done    (init_done),
        .ref_pulse    (ref_pulse),
        .cmd          (cmd)
    );

    sdram_io io_i (
        .CLK        (CLK),
        .rst        (rst),
        .cmd        (cmd),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .dram_dq    (dram_dq),
        .dram_addr  (dram_addr),
        .dram_ba    (dram_ba),
        .dram_dqm   (dram_dqm),
        .dram_clk   (dram_clk),
        .dram_cke   (dram_cke),
        .dram_cs_n  (dram_cs_n),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n)
    );

endmodule

`default_nettype wire

//--- source/sdram_io.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdram_consts.svh"

module sdram_io #(
    parameter int CAS = `SDRAM_CAS
) (
    input  logic               CLK,
    input  logic               rst,
    input  sdram_pkg::cmd_t    cmd,
    output sdram_pkg::rd_rsp_t rsp,
    output logic               rsp_valid,
    inout  wire  [15:0]        dram_dq,
    output logic [12:0]        dram_addr,
    output logic [1:0]         dram_ba,
    output logic [1:0]         dram_dqm,
    output logic               dram_clk,
    output logic               dram_cke,
    output logic               dram_cs_n,
    output logic               dram_ras_n,
    output logic               dram_cas_n,
    output logic               dram_we_n
);
    import sdram_pkg::*;

    // Pin register, CAS cycles in the DRAM, DQ capture register
    localparam int RD_LAT = CAS + 2;

    logic              ras_n_d;
    logic              cas_n_d;
    logic              we_n_d;
    logic              dq_oe_d;
    logic              rd_d;
    logic [12:0]       addr_d;
    logic [1:0]        ba_d;
    logic [15:0]       dq_out;
    logic              dq_oe;
    logic [15:0]       dq_in;
    tag_t [RD_LAT-1:0] tag_pipe;
    logic [RD_LAT-1:0] vld_pipe;

    always_comb begin
        ras_n_d = 1'b1;
        cas_n_d = 1'b1;
        we_n_d  = 1'b1;
        dq_oe_d = 1'b0;
        rd_d    = 1'b0;
        addr_d  = cmd.addr;
        ba_d    = cmd.bank;
        case (cmd.op)
            OP_REF: begin
                ras_n_d = 1'b0;
                cas_n_d = 1'b0;
            end
            OP_PRE: begin
                ras_n_d = 1'b0;
                we_n_d  = 1'b0;
            end
            OP_ACT: ras_n_d = 1'b0;
            OP_WRITE: begin
                cas_n_d = 1'b0;
                we_n_d  = 1'b0;
                dq_oe_d = 1'b1;
            end
            OP_READ: begin
                cas_n_d = 1'b0;
                rd_d    = 1'b1;
            end
            OP_MRS: begin
                ras_n_d          = 1'b0;
                cas_n_d          = 1'b0;
                we_n_d           = 1'b0;
                {ba_d, addr_d}   = cmd.data[14:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            dram_cs_n  <= 1'b1; // Deselected while in reset
            dram_ras_n <= 1'b1;
            dram_cas_n <= 1'b1;
            dram_we_n  <= 1'b1;
            dq_oe      <= 1'b0;
            vld_pipe   <= '0;
        end else begin
            dram_cs_n  <= 1'b0;
            dram_ras_n <= ras_n_d;
            dram_cas_n <= cas_n_d;
            dram_we_n  <= we_n_d;
            dq_oe      <= dq_oe_d;
            vld_pipe   <= {vld_pipe[RD_LAT-2:0], rd_d};
        end
    end

    always_ff @(posedge CLK) begin
        dram_addr <= addr_d;
        dram_ba   <= ba_d;
        dq_out    <= cmd.data;
        dq_in     <= dram_dq;
        tag_pipe  <= {tag_pipe[RD_LAT-2:0], cmd.data[7:0]};
    end

    assign dram_dq  = dq_oe ? dq_out : 'z;
    assign dram_clk = CLK;
    assign dram_cke = 1'b1;  // No power-down
    assign dram_dqm = 2'b00; // Full-word accesses only

    assign rsp       = '{data: dq_in, tag: tag_pipe[RD_LAT-1]};
    assign rsp_valid = vld_pipe[RD_LAT-1];

endmodule

`default_nettype wire

//--- source/sdram_pkg.sv
`default_nettype none

`include "sdram_consts.svh"

package sdram_pkg;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_REF,
        OP_PRE,
        OP_ACT,
        OP_WRITE,
        OP_READ,
        OP_MRS
    } op_t;

    typedef enum logic [2:0] {
        S_INIT_WAIT,
        S_PRECHARGE,
        S_REFRESH,  // Init refreshes only
        S_MODE_SET,
        S_IDLE,
        S_ACTIVATE,
        S_ACCESS,
        S_RECOVER   // Periodic refresh recovery
    } seq_state_t;

    typedef logic [`SDRAM_DATA_W-1:0] data_t;
    typedef logic [`SDRAM_TAG_W-1:0]  tag_t;

    typedef struct packed {
        logic                     write;
        logic [`SDRAM_BANK_W-1:0] bank;
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_COL_W-1:0]  col;
        data_t                    data;
        tag_t                     tag;
    } host_req_t;

    // READ puts the tag in data, MRS puts the mode word there
    typedef struct packed {
        op_t                      op;
        logic [`SDRAM_BANK_W-1:0] bank;
        logic [`SDRAM_ROW_W-1:0]  addr;
        data_t                    data;
    } cmd_t;

    typedef struct packed {
        data_t data;
        tag_t  tag;
    } rd_rsp_t;

endpackage

`default_nettype wire

//--- vlog.f
+incdir+source
source/sdram_pkg.sv
source/sdram_cfg_regs.sv
source/sdram_cmd_seq.sv
source/sdram_io.sv
source/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/sdram_checker.sv
bench/sdram_tb.sv
